/* src.f */
design/rv_isa_pkg.sv
design/core_pkg.sv
design/decoder.sv
design/imm_gen.sv
design/alu.sv
design/regfile.sv
design/fetch_unit.sv
design/lsu.sv
design/rv_core.sv
bench/tb_core.sv

/* run.sh */
#!/bin/sh
# Build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -f src.f --top-module tb_core \
	-Mdir obj_dir -o tb_core_sim
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/tb_core_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
	echo "Simulation reported failures, see sim.log"
	exit 1
fi

echo "Simulation passed"
exit 0

/* bench/tb_core.sv */
`timescale 1ns/10ps

module tb_core;

	localparam int RESET_CYCLES = 16;
	localparam int NUM_TESTS    = 6;
	localparam int PROG_CYCLES  = 214;   // Sum of all program lengths
	localparam int MAX_CYCLES   = 2 * (PROG_CYCLES + NUM_TESTS * (RESET_CYCLES + 1));
	localparam core_pkg::word_t LOAD_WORD = 32'h7ff2_8093;   // Mixed sign bytes and halves
	localparam core_pkg::word_t MARKER    = 32'h0000_05a7;

	logic                clk;
	logic                reset;
	core_pkg::word_t     imem_addr;
	rv_isa_pkg::inst_t   imem_data;
	core_pkg::dmem_req_t dmem_req;
	core_pkg::word_t     dmem_rdata;

	core_pkg::word_t imem [256];
	core_pkg::word_t dmem [256];

	int              errors      = 0;
	int              checks      = 0;
	int              tests       = 0;
	int              cycles      = 0;
	int              preset_idx  = -1;   // Preset data word index or -1 for none
	core_pkg::word_t preset_word = '0;

	core_pkg::word_t prog [$];
	core_pkg::word_t exp_addr [$];
	core_pkg::word_t exp_val [$];
	string           exp_name [$];
	core_pkg::word_t next_exp [core_pkg::word_t];   // Expected next PC after a branch or jump

	rv_core DUT (
		.clk        (clk),
		.reset      (reset),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_req   (dmem_req),
		.dmem_rdata (dmem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Word-indexed memories with combinational read
	assign imem_data  = imem[imem_addr[9:2]];
	assign dmem_rdata = dmem[dmem_req.addr[9:2]];

	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 256; i++) begin
				dmem[i] <= fill_word(i);
			end
			if (preset_idx >= 0)
				dmem[preset_idx[7:0]] <= preset_word;
		end else if (dmem_req.we) begin
			dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run exceeded %0d cycles", MAX_CYCLES);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	function automatic core_pkg::word_t fill_word(input int idx);
		return 32'hbad0_0000 | (idx << 2);
	endfunction

	// RV32I encoders take operands in assembly order
	function automatic core_pkg::word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
			input int rd, input int rs1, input int rs2);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], rv_isa_pkg::OP};
	endfunction

	function automatic core_pkg::word_t enc_i(input rv_isa_pkg::opcode_t op,
			input logic [2:0] f3, input int rd, input int rs1, input core_pkg::word_t imm);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
	endfunction

	function automatic core_pkg::word_t enc_s(input int rs2, input int rs1,
			input core_pkg::word_t imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], rv_isa_pkg::F3_LW, imm[4:0], rv_isa_pkg::STORE};
	endfunction

	function automatic core_pkg::word_t enc_b(input logic [2:0] f3, input int rs1,
			input int rs2, input core_pkg::word_t imm);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11],
			rv_isa_pkg::BRANCH};
	endfunction

	function automatic core_pkg::word_t enc_j(input int rd, input core_pkg::word_t imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_isa_pkg::JAL};
	endfunction

	function automatic core_pkg::word_t enc_u(input rv_isa_pkg::opcode_t op, input int rd,
			input logic [19:0] imm20);
		return {imm20, rd[4:0], op};
	endfunction

	function automatic core_pkg::word_t pc_now();
		return core_pkg::word_t'(prog.size() * 4);
	endfunction

	task automatic emit(input core_pkg::word_t w);
		prog.push_back(w);
	endtask

	task automatic load_const(input int rd, input core_pkg::word_t v);
		core_pkg::word_t hi;
		hi = (v + 32'h800) >> 12;   // ADDI sign-extends its low twelve bits
		emit(enc_u(rv_isa_pkg::LUI, rd, hi[19:0]));
		emit(enc_i(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD, rd, rd, v));
	endtask

	task automatic push_exp(input core_pkg::word_t addr, input core_pkg::word_t val,
			input string name);
		exp_addr.push_back(addr);
		exp_val.push_back(val);
		exp_name.push_back(name);
	endtask

	function automatic core_pkg::word_t next_slot();
		return 32'h200 + 4 * exp_val.size();
	endfunction

	task automatic store_check(input int rs2, input core_pkg::word_t val, input string name);
		core_pkg::word_t addr;
		addr = next_slot();
		emit(enc_s(rs2, 0, addr));
		push_exp(addr, val, name);
	endtask

	task automatic check_word(input core_pkg::word_t got, input core_pkg::word_t exp,
			input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_pc(input core_pkg::word_t exp);
		checks++;
		if (imem_addr !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: imem_addr %h expected %h", $time, imem_addr, exp);
		end
	endtask

	task automatic begin_prog();
		prog.delete();
		exp_addr.delete();
		exp_val.delete();
		exp_name.delete();
		next_exp.delete();
		preset_idx = -1;
	endtask

	task automatic run_prog(input string name);
		int              err0;
		int              n;
		core_pkg::word_t prev;
		err0 = errors;
		emit(enc_j(0, 32'h0));   // Parks the core on a JAL to itself
		n = prog.size();
		@(posedge clk);
		#1 reset = 1'b1;
		for (int i = 0; i < 256; i++) begin
			imem[i] = (i < n) ? prog[i] : '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset = 1'b0;
		check_pc(32'h0);
		for (int i = 0; i < n; i++) begin
			prev = imem_addr;
			@(posedge clk);
			#1;
			if (next_exp.exists(prev))
				check_pc(next_exp[prev]);
		end
		for (int k = 0; k < exp_val.size(); k++) begin
			check_word(dmem[exp_addr[k][9:2]], exp_val[k], exp_name[k]);
		end
		tests++;
		$display("test %s: %s", name, (errors == err0) ? "ok" : "FAILED");
	endtask

	task automatic r_op(input logic [6:0] f7, input logic [2:0] f3, input core_pkg::word_t exp,
			input string name);
		emit(enc_r(f7, f3, 3, 1, 2));
		store_check(3, exp, name);
	endtask

	task automatic i_op(input core_pkg::word_t imm, input logic [2:0] f3,
			input core_pkg::word_t exp, input string name);
		emit(enc_i(rv_isa_pkg::OP_IMM, f3, 3, 1, imm));
		store_check(3, exp, name);
	endtask

	task automatic alu_test();
		core_pkg::word_t a;
		core_pkg::word_t b;
		core_pkg::word_t im;
		core_pkg::word_t ie;
		logic [4:0]      sh;
		begin_prog();
		a  = $urandom();
		b  = $urandom();
		im = $urandom();
		sh = 5'($urandom());
		ie = {{20{im[11]}}, im[11:0]};
		load_const(1, a);
		load_const(2, b);
		r_op(7'h00, rv_isa_pkg::F3_ADD, a + b, "ADD");
		r_op(7'h20, rv_isa_pkg::F3_ADD, a - b, "SUB");
		r_op(7'h00, rv_isa_pkg::F3_SLL, a << b[4:0], "SLL");
		r_op(7'h00, rv_isa_pkg::F3_SLT, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0, "SLT");
		r_op(7'h00, rv_isa_pkg::F3_SLTU, (a < b) ? 32'd1 : 32'd0, "SLTU");
		r_op(7'h00, rv_isa_pkg::F3_XOR, a ^ b, "XOR");
		r_op(7'h00, rv_isa_pkg::F3_SR, a >> b[4:0], "SRL");
		r_op(7'h20, rv_isa_pkg::F3_SR, core_pkg::word_t'($signed(a) >>> b[4:0]), "SRA");
		r_op(7'h00, rv_isa_pkg::F3_OR, a | b, "OR");
		r_op(7'h00, rv_isa_pkg::F3_AND, a & b, "AND");
		i_op(im, rv_isa_pkg::F3_ADD, a + ie, "ADDI");
		i_op(im, rv_isa_pkg::F3_SLT, ($signed(a) < $signed(ie)) ? 32'd1 : 32'd0, "SLTI");
		i_op(im, rv_isa_pkg::F3_SLTU, (a < ie) ? 32'd1 : 32'd0, "SLTIU");
		i_op(im, rv_isa_pkg::F3_XOR, a ^ ie, "XORI");
		i_op(im, rv_isa_pkg::F3_OR, a | ie, "ORI");
		i_op(im, rv_isa_pkg::F3_AND, a & ie, "ANDI");
		i_op({20'b0, 7'h00, sh}, rv_isa_pkg::F3_SLL, a << sh, "SLLI");
		i_op({20'b0, 7'h00, sh}, rv_isa_pkg::F3_SR, a >> sh, "SRLI");
		i_op({20'b0, 7'h20, sh}, rv_isa_pkg::F3_SR, core_pkg::word_t'($signed(a) >>> sh),
			"SRAI");
		run_prog("alu");
	endtask

	task automatic upper_test();
		logic [19:0]     u;
		core_pkg::word_t p;
		begin_prog();
		repeat (2) begin
			u = 20'($urandom());
			emit(enc_u(rv_isa_pkg::LUI, 5, u));
			store_check(5, {u, 12'h000}, "LUI");
			u = 20'($urandom());
			p = pc_now();
			emit(enc_u(rv_isa_pkg::AUIPC, 6, u));
			store_check(6, p + {u, 12'h000}, "AUIPC");   // Relative to its own address
		end
		run_prog("upper");
	endtask

	task automatic load_test();
		logic [7:0]  b8;
		logic [15:0] h16;
		begin_prog();
		preset_idx  = 64;   // Byte address 0x100
		preset_word = LOAD_WORD;
		for (int off = 0; off < 4; off++) begin
			b8 = LOAD_WORD[8*off +: 8];
			emit(enc_i(rv_isa_pkg::LOAD, rv_isa_pkg::F3_LB, 3, 0, 32'h100 + off));
			store_check(3, {{24{b8[7]}}, b8}, $sformatf("LB +%0d", off));
			emit(enc_i(rv_isa_pkg::LOAD, rv_isa_pkg::F3_LBU, 3, 0, 32'h100 + off));
			store_check(3, {24'b0, b8}, $sformatf("LBU +%0d", off));
		end
		for (int off = 0; off < 4; off += 2) begin
			h16 = LOAD_WORD[8*off +: 16];
			emit(enc_i(rv_isa_pkg::LOAD, rv_isa_pkg::F3_LH, 3, 0, 32'h100 + off));
			store_check(3, {{16{h16[15]}}, h16}, $sformatf("LH +%0d", off));
			emit(enc_i(rv_isa_pkg::LOAD, rv_isa_pkg::F3_LHU, 3, 0, 32'h100 + off));
			store_check(3, {16'b0, h16}, $sformatf("LHU +%0d", off));
		end
		emit(enc_i(rv_isa_pkg::LOAD, rv_isa_pkg::F3_LW, 3, 0, 32'h100));
		store_check(3, LOAD_WORD, "LW");
		run_prog("loads");
	endtask

	// Branch over a JAL that skips the marker store
	task automatic br_case(input logic [2:0] f3, input core_pkg::word_t a,
			input core_pkg::word_t b, input logic taken, input string name);
		core_pkg::word_t p;
		core_pkg::word_t addr;
		load_const(1, a);
		load_const(2, b);
		p = pc_now();
		emit(enc_b(f3, 1, 2, 32'd8));
		next_exp[p] = taken ? p + 8 : p + 4;
		emit(enc_j(0, 32'd8));
		next_exp[p + 4] = p + 12;
		addr = next_slot();
		emit(enc_s(7, 0, addr));
		push_exp(addr, taken ? MARKER : fill_word(int'(addr[9:2])), name);
	endtask

	task automatic branch_test();
		core_pkg::word_t r;
		core_pkg::word_t n;
		core_pkg::word_t p;
		begin_prog();
		emit(enc_i(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD, 7, 0, MARKER));
		r = $urandom();
		n = $urandom() | 32'h8000_0000;   // Negative signed but large unsigned
		p = $urandom() & 32'h7fff_ffff;
		br_case(rv_isa_pkg::F3_BEQ, r, r, 1'b1, "BEQ equal");
		br_case(rv_isa_pkg::F3_BEQ, n, p, 1'b0, "BEQ differ");
		br_case(rv_isa_pkg::F3_BNE, n, p, 1'b1, "BNE differ");
		br_case(rv_isa_pkg::F3_BNE, r, r, 1'b0, "BNE equal");
		br_case(rv_isa_pkg::F3_BLT, n, p, 1'b1, "BLT neg pos");
		br_case(rv_isa_pkg::F3_BLT, p, n, 1'b0, "BLT pos neg");
		br_case(rv_isa_pkg::F3_BGE, p, n, 1'b1, "BGE pos neg");
		br_case(rv_isa_pkg::F3_BGE, n, p, 1'b0, "BGE neg pos");
		br_case(rv_isa_pkg::F3_BLTU, p, n, 1'b1, "BLTU small big");
		br_case(rv_isa_pkg::F3_BLTU, n, p, 1'b0, "BLTU big small");
		br_case(rv_isa_pkg::F3_BGEU, n, p, 1'b1, "BGEU big small");
		br_case(rv_isa_pkg::F3_BGEU, p, n, 1'b0, "BGEU small big");
		run_prog("branch");
	endtask

	task automatic jalr_case(input core_pkg::word_t imm, input string name);
		core_pkg::word_t q;
		q = pc_now() + 8;   // After the two-instruction constant load
		load_const(2, q + 8 - imm);
		emit(enc_i(rv_isa_pkg::JALR, 3'b000, 3, 2, imm));
		next_exp[q] = q + 8;
		emit(enc_i(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD, 3, 0, 32'hffff_ffff));   // Skipped
		store_check(3, q + 4, name);
	endtask

	task automatic jump_test();
		core_pkg::word_t p;
		begin_prog();
		p = pc_now();
		emit(enc_j(1, 32'd8));
		next_exp[p] = p + 8;
		emit(enc_i(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD, 1, 0, 32'hffff_ffff));   // Skipped
		store_check(1, p + 4, "JAL link");
		jalr_case(32'd4, "JALR forward offset");
		jalr_case(-32'd4, "JALR negative offset");
		run_prog("jump");
	endtask

	task automatic x0_test();
		begin_prog();
		for (int r = 1; r < 32; r++) begin
			store_check(r, '0, $sformatf("x%0d after reset", r));
		end
		emit(enc_i(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD, 0, 0, 32'h123));
		emit(enc_u(rv_isa_pkg::LUI, 0, 20'habcde));
		store_check(0, '0, "x0 after writes");
		run_prog("x0");
	endtask

	initial begin
		void'($urandom(32'h6071));
		reset = 1'b1;
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0;
		end
		alu_test();
		upper_test();
		load_test();
		branch_test();
		jump_test();
		x0_test();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* design/rv_core.sv */
`timescale 1ns/10ps

module rv_core (
	input  logic                clk,
	input  logic                reset,
	output core_pkg::word_t     imem_addr,
	input  rv_isa_pkg::inst_t   imem_data,
	output core_pkg::dmem_req_t dmem_req,
	input  core_pkg::word_t     dmem_rdata
);

	core_pkg::ctrl_t ctrl;
	core_pkg::word_t imm;
	core_pkg::word_t rs1_data;
	core_pkg::word_t rs2_data;
	core_pkg::word_t alu_a;
	core_pkg::word_t alu_b;
	core_pkg::word_t alu_result;   // Memory address and jump target
	core_pkg::word_t pc;
	core_pkg::word_t pc4;
	core_pkg::word_t load_data;
	core_pkg::word_t wb_data;

	assign imem_addr = pc;

	decoder u_decoder (
		.inst (imem_data),
		.ctrl (ctrl)
	);

	imm_gen u_imm_gen (
		.inst    (imem_data),
		.imm_sel (ctrl.imm_sel),
		.imm     (imm)
	);

	regfile u_regfile (
		.clk      (clk),
		.reset    (reset),
		.rs1      (imem_data.r.rs1),
		.rs2      (imem_data.r.rs2),
		.rd       (imem_data.r.rd),
		.we       (ctrl.reg_we),
		.wdata    (wb_data),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	assign alu_a = ctrl.a_pc  ? pc  : rs1_data;
	assign alu_b = ctrl.b_imm ? imm : rs2_data;

	alu u_alu (
		.a      (alu_a),
		.b      (alu_b),
		.op     (ctrl.alu_op),
		.result (alu_result)
	);

	fetch_unit u_fetch (
		.clk      (clk),
		.reset    (reset),
		.inst     (imem_data),
		.ctrl     (ctrl),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.target   (alu_result),
		.pc       (pc),
		.pc4      (pc4)
	);

	lsu u_lsu (
		.inst       (imem_data),
		.ctrl       (ctrl),
		.addr       (alu_result),
		.store_data (rs2_data),
		.dmem_rdata (dmem_rdata),
		.dmem_req   (dmem_req),
		.load_data  (load_data)
	);

	always_comb begin
		case (ctrl.wb_sel)
			core_pkg::WB_LOAD: wb_data = load_data;
			core_pkg::WB_ALU:  wb_data = alu_result;
			core_pkg::WB_PC4:  wb_data = pc4;   // Link address
			default:           wb_data = alu_result;
		endcase
	end

endmodule

/* design/lsu.sv */
`timescale 1ns/10ps

module lsu (
	input  rv_isa_pkg::inst_t   inst,
	input  core_pkg::ctrl_t     ctrl,
	input  core_pkg::word_t     addr,
	input  core_pkg::word_t     store_data,
	input  core_pkg::word_t     dmem_rdata,
	output core_pkg::dmem_req_t dmem_req,
	output core_pkg::word_t     load_data
);

	logic [7:0]  lane_b;
	logic [15:0] lane_h;

	assign dmem_req.addr  = addr;
	assign dmem_req.wdata = store_data;
	assign dmem_req.we    = ctrl.mem_we;

	// Lane picked by the low address bits
	assign lane_b = dmem_rdata[{addr[1:0], 3'b000} +: 8];
	assign lane_h = addr[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

	always_comb begin
		case (inst.i.funct3)
			rv_isa_pkg::F3_LB:  load_data = {{24{lane_b[7]}}, lane_b};
			rv_isa_pkg::F3_LH:  load_data = {{16{lane_h[15]}}, lane_h};
			rv_isa_pkg::F3_LW:  load_data = dmem_rdata;
			rv_isa_pkg::F3_LBU: load_data = {24'b0, lane_b};
			rv_isa_pkg::F3_LHU: load_data = {16'b0, lane_h};
			default:            load_data = '0;
		endcase
	end

endmodule

/* design/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit (
	input  logic              clk,
	input  logic              reset,
	input  rv_isa_pkg::inst_t inst,
	input  core_pkg::ctrl_t   ctrl,
	input  core_pkg::word_t   rs1_data,
	input  core_pkg::word_t   rs2_data,
	input  core_pkg::word_t   target,
	output core_pkg::word_t   pc,
	output core_pkg::word_t   pc4
);

	logic            eq;
	logic            lt;
	logic            ltu;
	logic            cond;
	logic            redirect;
	core_pkg::word_t next_pc;

	assign eq  = (rs1_data == rs2_data);
	assign lt  = ($signed(rs1_data) < $signed(rs2_data));
	assign ltu = (rs1_data < rs2_data);

	always_comb begin
		case (inst.b.funct3)
			rv_isa_pkg::F3_BEQ:  cond = eq;
			rv_isa_pkg::F3_BNE:  cond = !eq;
			rv_isa_pkg::F3_BLT:  cond = lt;
			rv_isa_pkg::F3_BGE:  cond = !lt;
			rv_isa_pkg::F3_BLTU: cond = ltu;
			rv_isa_pkg::F3_BGEU: cond = !ltu;
			default:             cond = 1'b0;
		endcase
	end

	assign redirect = ctrl.is_jump || (ctrl.is_branch && cond);
	assign pc4      = pc + 32'd4;
	// JALR clears bit 0 of its target
	assign next_pc  = redirect ? {target[31:1], 1'b0} : pc4;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			pc <= '0;
		else
			pc <= next_pc;
	end

endmodule

/* design/regfile.sv */
`timescale 1ns/10ps

module regfile (
	input  logic                clk,
	input  logic                reset,
	input  core_pkg::reg_idx_t  rs1,
	input  core_pkg::reg_idx_t  rs2,
	input  core_pkg::reg_idx_t  rd,
	input  logic                we,
	input  core_pkg::word_t     wdata,
	output core_pkg::word_t     rs1_data,
	output core_pkg::word_t     rs2_data
);

	core_pkg::word_t regs [core_pkg::NREGS];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < core_pkg::NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (rd != '0)) begin
			regs[rd] <= wdata;   // x0 never written
		end
	end

	// Combinational reads
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* design/alu.sv */
`timescale 1ns/10ps

module alu (
	input  core_pkg::word_t   a,
	input  core_pkg::word_t   b,
	input  core_pkg::alu_op_t op,
	output core_pkg::word_t   result
);

	logic [4:0] shamt;

	assign shamt = b[4:0];   // RV32 uses only the low five bits

	always_comb begin
		case (op)
			core_pkg::ALU_ADD:    result = a + b;
			core_pkg::ALU_SUB:    result = a - b;
			core_pkg::ALU_SLL:    result = a << shamt;
			core_pkg::ALU_SLT:    result = core_pkg::word_t'($signed(a) < $signed(b));
			core_pkg::ALU_SLTU:   result = core_pkg::word_t'(a < b);
			core_pkg::ALU_XOR:    result = a ^ b;
			core_pkg::ALU_SRL:    result = a >> shamt;
			core_pkg::ALU_SRA:    result = $signed(a) >>> shamt;
			core_pkg::ALU_OR:     result = a | b;
			core_pkg::ALU_AND:    result = a & b;
			core_pkg::ALU_PASS_B: result = b;
			default:              result = '0;
		endcase
	end

endmodule

/* design/imm_gen.sv */
`timescale 1ns/10ps

module imm_gen (
	input  rv_isa_pkg::inst_t  inst,
	input  core_pkg::imm_sel_t imm_sel,
	output core_pkg::word_t    imm
);

	always_comb begin
		case (imm_sel)
			core_pkg::IMM_I:
				imm = {{20{inst.i.imm[11]}}, inst.i.imm};
			core_pkg::IMM_S:
				imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
			core_pkg::IMM_B:   // Halfword offset, bit 0 clear
				imm = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
					inst.b.imm10_5, inst.b.imm4_1, 1'b0};
			core_pkg::IMM_J:
				imm = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
					inst.j.imm11, inst.j.imm10_1, 1'b0};
			core_pkg::IMM_U:
				imm = {inst.u.imm31_12, 12'b0};
			default:
				imm = '0;
		endcase
	end

endmodule

/* design/decoder.sv */
`timescale 1ns/10ps

module decoder (
	input  rv_isa_pkg::inst_t inst,
	output core_pkg::ctrl_t   ctrl
);

	logic alt_bit;   // Instruction bit 30

	function automatic core_pkg::alu_op_t alu_dec(input logic [2:0] funct3, input logic alt);
		core_pkg::alu_op_t op;
		case (funct3)
			rv_isa_pkg::F3_ADD:  op = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
			rv_isa_pkg::F3_SLL:  op = core_pkg::ALU_SLL;
			rv_isa_pkg::F3_SLT:  op = core_pkg::ALU_SLT;
			rv_isa_pkg::F3_SLTU: op = core_pkg::ALU_SLTU;
			rv_isa_pkg::F3_XOR:  op = core_pkg::ALU_XOR;
			rv_isa_pkg::F3_SR:   op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
			rv_isa_pkg::F3_OR:   op = core_pkg::ALU_OR;
			rv_isa_pkg::F3_AND:  op = core_pkg::ALU_AND;
			default:             op = core_pkg::ALU_ADD;
		endcase
		return op;
	endfunction

	assign alt_bit = inst.r.funct7[5];

	always_comb begin
		ctrl = '0;   // Unknown opcodes fall through as no-ops
		case (inst.r.opcode)
			rv_isa_pkg::OP: begin
				ctrl.reg_we = 1'b1;
				ctrl.wb_sel = core_pkg::WB_ALU;
				ctrl.alu_op = alu_dec(inst.r.funct3, alt_bit);
			end
			rv_isa_pkg::OP_IMM: begin
				ctrl.reg_we  = 1'b1;
				ctrl.b_imm   = 1'b1;
				ctrl.imm_sel = core_pkg::IMM_I;
				ctrl.wb_sel  = core_pkg::WB_ALU;
				// Bit 30 is immediate data for ADDI, only shifts look at it
				ctrl.alu_op  = alu_dec(inst.i.funct3,
					alt_bit && (inst.i.funct3 == rv_isa_pkg::F3_SR));
			end
			rv_isa_pkg::LOAD: begin
				ctrl.reg_we  = 1'b1;
				ctrl.b_imm   = 1'b1;
				ctrl.imm_sel = core_pkg::IMM_I;
				ctrl.alu_op  = core_pkg::ALU_ADD;
				ctrl.wb_sel  = core_pkg::WB_LOAD;
			end
			rv_isa_pkg::STORE: begin
				ctrl.b_imm   = 1'b1;
				ctrl.imm_sel = core_pkg::IMM_S;
				ctrl.alu_op  = core_pkg::ALU_ADD;
				ctrl.mem_we  = (inst.s.funct3 == rv_isa_pkg::F3_LW);   // Word stores only
			end
			rv_isa_pkg::BRANCH: begin
				ctrl.a_pc      = 1'b1;
				ctrl.b_imm     = 1'b1;
				ctrl.imm_sel   = core_pkg::IMM_B;
				ctrl.alu_op    = core_pkg::ALU_ADD;   // Target = PC + imm
				ctrl.is_branch = 1'b1;
			end
			rv_isa_pkg::JAL: begin
				ctrl.reg_we  = 1'b1;
				ctrl.a_pc    = 1'b1;
				ctrl.b_imm   = 1'b1;
				ctrl.imm_sel = core_pkg::IMM_J;
				ctrl.alu_op  = core_pkg::ALU_ADD;
				ctrl.wb_sel  = core_pkg::WB_PC4;
				ctrl.is_jump = 1'b1;
			end
			rv_isa_pkg::JALR: begin
				ctrl.reg_we  = 1'b1;
				ctrl.b_imm   = 1'b1;
				ctrl.imm_sel = core_pkg::IMM_I;
				ctrl.alu_op  = core_pkg::ALU_ADD;   // rs1 + imm
				ctrl.wb_sel  = core_pkg::WB_PC4;
				ctrl.is_jump = 1'b1;
			end
			rv_isa_pkg::LUI: begin
				ctrl.reg_we  = 1'b1;
				ctrl.b_imm   = 1'b1;
				ctrl.imm_sel = core_pkg::IMM_U;
				ctrl.alu_op  = core_pkg::ALU_PASS_B;
				ctrl.wb_sel  = core_pkg::WB_ALU;
			end
			rv_isa_pkg::AUIPC: begin
				ctrl.reg_we  = 1'b1;
				ctrl.a_pc    = 1'b1;
				ctrl.b_imm   = 1'b1;
				ctrl.imm_sel = core_pkg::IMM_U;
				ctrl.alu_op  = core_pkg::ALU_ADD;
				ctrl.wb_sel  = core_pkg::WB_ALU;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

/* design/core_pkg.sv */
package core_pkg;

	localparam int XLEN  = 32;
	localparam int NREGS = 32;

	typedef logic [XLEN-1:0]          word_t;
	typedef logic [$clog2(NREGS)-1:0] reg_idx_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B   // LUI
	} alu_op_t;

	typedef enum logic [2:0] {
		IMM_I,
		IMM_S,
		IMM_B,
		IMM_J,
		IMM_U
	} imm_sel_t;

	typedef enum logic [1:0] {
		WB_LOAD,
		WB_ALU,
		WB_PC4
	} wb_sel_t;

	// Decoded control, 15 bits
	typedef struct packed {
		logic     reg_we;
		logic     a_pc;      // A operand is PC
		logic     b_imm;     // B operand is immediate
		alu_op_t  alu_op;
		imm_sel_t imm_sel;
		wb_sel_t  wb_sel;
		logic     mem_we;
		logic     is_branch;
		logic     is_jump;
	} ctrl_t;

	typedef struct packed {
		word_t addr;    // Byte address
		word_t wdata;
		logic  we;
	} dmem_req_t;

endpackage

/* design/rv_isa_pkg.sv */
package rv_isa_pkg;

	// Major opcodes of the RV32I base set
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111
	} opcode_t;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_t    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcode_t     opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;   // imm[11:5]
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;   // imm[4:0]
		opcode_t    opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		opcode_t    opcode;
	} b_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		opcode_t    opcode;
	} j_fmt_t;

	typedef struct packed {
		logic [19:0] imm31_12;
		logic [4:0]  rd;
		opcode_t     opcode;
	} u_fmt_t;

	// One instruction word, six views
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		j_fmt_t j;
		u_fmt_t u;
	} inst_t;

	// ALU funct3
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;   // SRL or SRA by bit 30
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	// Load funct3, SW shares the LW code
	localparam logic [2:0] F3_LB   = 3'b000;
	localparam logic [2:0] F3_LH   = 3'b001;
	localparam logic [2:0] F3_LW   = 3'b010;
	localparam logic [2:0] F3_LBU  = 3'b100;
	localparam logic [2:0] F3_LHU  = 3'b101;

	// Branch funct3
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

endpackage
